/* design/axis_dist_ram_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// LUT-RAM word FIFO, holds DEPTH+1 words. With bp_en low, words that meet
// a full RAM are lost and the packet is only flagged, never repaired
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "axis_fifo_params.svh"

module axis_dist_ram_fifo (
    input  logic          axis_out,
    input  logic          rst_n,
    input  logic          bp_en,
    axis_stream_if.sink   fifo_in,
    axis_stream_if.source fifo_out,
    output logic          in_overflow
);

    import axis_fifo_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // Storage and pointers

    // Async read, maps to distributed RAM
    axis_beat_t mem [`AXIS_FIFO_DEPTH];

    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;
    fifo_addr_t wr_addr;
    fifo_addr_t rd_addr;
    logic       full;
    logic       empty;

    axis_beat_t wr_beat;
    axis_beat_t rd_beat;

    // Write side control
    logic wr_hs;
    logic wr_en;
    // Some word of the open packet was lost
    logic drop_flag;

    // Output register
    axis_beat_t out_beat;
    logic       out_valid;
    logic       rd_hs;
    logic       load;

    assign wr_addr = wr_ptr[FIFO_ADDR_W-1:0];
    assign rd_addr = rd_ptr[FIFO_ADDR_W-1:0];

    // Same address, wrap bits differ
    assign full  = (wr_addr == rd_addr) && (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]);
    assign empty = (wr_ptr == rd_ptr);

    ////////////////////////////////////////////////////////////////////////
    // Write side

    // No back-pressure mode takes every word
    assign fifo_in.tready = ~bp_en | ~full;

    assign wr_hs = fifo_in.tvalid & fifo_in.tready;
    assign wr_en = wr_hs & ~full;

    assign wr_beat = '{
        data:  fifo_in.tdata,
        keep:  fifo_in.tkeep,
        last:  fifo_in.tlast,
        trunc: fifo_in.ttrunc
    };

    always_ff @(posedge axis_out) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            drop_flag   <= 1'b0;
            in_overflow <= 1'b0;
        end else begin
            in_overflow <= 1'b0;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (wr_hs) begin
                if (fifo_in.tlast) begin
                    // Tlast word itself may be the lost one
                    in_overflow <= drop_flag | full;
                    drop_flag   <= 1'b0;
                end else if (full) begin
                    drop_flag <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Read side with prefetch

    assign rd_beat = mem[rd_addr];
    assign rd_hs   = out_valid & fifo_out.tready;
    // Refill when empty or emptied this cycle
    assign load    = ~empty & (~out_valid | rd_hs);

    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (load) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (rd_hs) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_out) begin
        if (load) begin
            out_beat <= rd_beat;
        end
    end

    assign fifo_out.tvalid = out_valid;
    assign fifo_out.tdata  = out_beat.data;
    assign fifo_out.tkeep  = out_beat.keep;
    assign fifo_out.tlast  = out_beat.last;
    assign fifo_out.ttrunc = out_beat.trunc;

endmodule

/* design/axis_fifo_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Types shared by the packet path, sized from the params header
////////////////////////////////////////////////////////////////////////////

`include "axis_fifo_params.svh"

package axis_fifo_pkg;

    // Address bits of the RAM
    localparam int FIFO_ADDR_W = $clog2(`AXIS_FIFO_DEPTH);

    // Stream payload fields
    typedef logic [`AXIS_DATA_BYTES*8-1:0] data_t;
    typedef logic [`AXIS_DATA_BYTES-1:0]   keep_t;

    // One stored word, 9 bits per byte plus last and trunc
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        logic  trunc;
    } axis_beat_t;

    // RAM address, and pointers with one extra wrap bit
    typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;
    typedef logic [FIFO_ADDR_W:0]   fifo_ptr_t;

    // Word count inside one packet, up to the limit
    typedef logic [$clog2(`AXIS_MAX_PKT_WORDS+1)-1:0] pkt_words_t;

    // Byte total of one packet of up to the limit
    typedef logic [$clog2(`AXIS_MAX_PKT_WORDS*`AXIS_DATA_BYTES+1)-1:0] pkt_bytes_t;

    // Limiter states
    typedef enum logic {
        LIM_PASS,
        LIM_DISCARD
    } lim_state_e;

endpackage

/* design/axis_fifo_top.sv */
////////////////////////////////////////////////////////////////////////////
// Limiter, FIFO and byte counter on one clock, two cycles at idle output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module axis_fifo_top (
    input  logic                      axis_out,
    input  logic                      rst_n,
    // Run-time FIFO mode, high for back-pressure
    input  logic                      bp_en,

    // Input stream
    input  logic                      in_tvalid,
    output logic                      in_tready,
    input  axis_fifo_pkg::data_t      in_tdata,
    input  axis_fifo_pkg::keep_t      in_tkeep,
    input  logic                      in_tlast,

    // Output stream
    output logic                      out_tvalid,
    input  logic                      out_tready,
    output axis_fifo_pkg::data_t      out_tdata,
    output axis_fifo_pkg::keep_t      out_tkeep,
    output logic                      out_tlast,

    // Side reports
    output logic                      in_overflow,
    output logic                      pkt_done,
    output axis_fifo_pkg::pkt_bytes_t pkt_bytes,
    output logic                      pkt_truncated
);

    ////////////////////////////////////////////////////////////////////////
    // Internal links

    // Limiter to FIFO
    axis_stream_if lim_s ();
    // FIFO to counter
    axis_stream_if buf_s ();

    ////////////////////////////////////////////////////////////////////////
    // Stages

    axis_pkt_limiter u_limiter (
        .axis_out  (axis_out),
        .rst_n     (rst_n),
        .in_tvalid (in_tvalid),
        .in_tready (in_tready),
        .in_tdata  (in_tdata),
        .in_tkeep  (in_tkeep),
        .in_tlast  (in_tlast),
        .lim_s     (lim_s.source)
    );

    axis_dist_ram_fifo u_fifo (
        .axis_out    (axis_out),
        .rst_n       (rst_n),
        .bp_en       (bp_en),
        .fifo_in     (lim_s.sink),
        .fifo_out    (buf_s.source),
        .in_overflow (in_overflow)
    );

    axis_pkt_byte_counter u_counter (
        .axis_out      (axis_out),
        .rst_n         (rst_n),
        .cnt_in        (buf_s.sink),
        .out_tvalid    (out_tvalid),
        .out_tready    (out_tready),
        .out_tdata     (out_tdata),
        .out_tkeep     (out_tkeep),
        .out_tlast     (out_tlast),
        .pkt_done      (pkt_done),
        .pkt_bytes     (pkt_bytes),
        .pkt_truncated (pkt_truncated)
    );

endmodule

/* design/axis_pkt_byte_counter.sv */
////////////////////////////////////////////////////////////////////////////
// Pass-through byte counter. A packet that lost its tlast in the FIFO
// merges with the next one and its count may wrap
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module axis_pkt_byte_counter (
    input  logic                       axis_out,
    input  logic                       rst_n,
    axis_stream_if.sink                cnt_in,
    output logic                       out_tvalid,
    input  logic                       out_tready,
    output axis_fifo_pkg::data_t       out_tdata,
    output axis_fifo_pkg::keep_t       out_tkeep,
    output logic                       out_tlast,
    output logic                       pkt_done,
    output axis_fifo_pkg::pkt_bytes_t  pkt_bytes,
    output logic                       pkt_truncated
);

    import axis_fifo_pkg::*;

    logic       out_hs;
    // Bytes carried by the current word
    pkt_bytes_t beat_bytes;
    // Bytes of the open packet so far
    pkt_bytes_t byte_sum;

    ////////////////////////////////////////////////////////////////////////
    // Stream pass-through

    assign out_tvalid    = cnt_in.tvalid;
    assign out_tdata     = cnt_in.tdata;
    assign out_tkeep     = cnt_in.tkeep;
    assign out_tlast     = cnt_in.tlast;
    assign cnt_in.tready = out_tready;

    assign out_hs     = cnt_in.tvalid & out_tready;
    assign beat_bytes = pkt_bytes_t'($countones(cnt_in.tkeep));

    ////////////////////////////////////////////////////////////////////////
    // Running sum and report

    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            byte_sum <= '0;
            pkt_done <= 1'b0;
        end else begin
            pkt_done <= out_hs & cnt_in.tlast;
            if (out_hs) begin
                if (cnt_in.tlast) begin
                    // Restart for the next packet
                    byte_sum <= '0;
                end else begin
                    byte_sum <= byte_sum + beat_bytes;
                end
            end
        end
    end

    // Report held until the next packet ends
    always_ff @(posedge axis_out) begin
        if (out_hs && cnt_in.tlast) begin
            pkt_bytes     <= byte_sum + beat_bytes;
            pkt_truncated <= cnt_in.ttrunc;
        end
    end

endmodule

/* design/axis_pkt_limiter.sv */
////////////////////////////////////////////////////////////////////////////
// Cuts packets at AXIS_MAX_PKT_WORDS, the dropped tail is never stalled
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "axis_fifo_params.svh"

module axis_pkt_limiter (
    input  logic                 axis_out,
    input  logic                 rst_n,
    input  logic                 in_tvalid,
    output logic                 in_tready,
    input  axis_fifo_pkg::data_t in_tdata,
    input  axis_fifo_pkg::keep_t in_tkeep,
    input  logic                 in_tlast,
    axis_stream_if.source        lim_s
);

    import axis_fifo_pkg::*;

    // Index of the last allowed word, counting from zero
    localparam pkt_words_t LIMIT_LAST = pkt_words_t'(`AXIS_MAX_PKT_WORDS - 1);

    lim_state_e state;
    // Words already passed in this packet
    pkt_words_t wcnt;
    logic       at_limit;
    logic       pass_hs;

    ////////////////////////////////////////////////////////////////////////
    // Forward path

    // Current word is the last one allowed
    assign at_limit = (wcnt == LIMIT_LAST);

    // Discard swallows everything, so ready is forced
    assign in_tready = (state == LIM_DISCARD) ? 1'b1 : lim_s.tready;

    assign lim_s.tvalid = in_tvalid && (state == LIM_PASS);
    assign lim_s.tdata  = in_tdata;
    assign lim_s.tkeep  = in_tkeep;
    // Force last at the limit
    assign lim_s.tlast  = in_tlast | at_limit;
    // Trunc only when the real end is still to come
    assign lim_s.ttrunc = at_limit & ~in_tlast;

    assign pass_hs = lim_s.tvalid & lim_s.tready;

    ////////////////////////////////////////////////////////////////////////
    // State and word count

    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            state <= LIM_PASS;
            wcnt  <= '0;
        end else begin
            case (state)
                LIM_PASS: begin
                    if (pass_hs) begin
                        if (lim_s.tlast) begin
                            // New packet starts next word
                            wcnt <= '0;
                        end else begin
                            wcnt <= wcnt + 1'b1;
                        end
                        // Cut packet, drop the tail
                        if (lim_s.ttrunc) begin
                            state <= LIM_DISCARD;
                        end
                    end
                end
                LIM_DISCARD: begin
                    // Wait for the real end of the packet
                    if (in_tvalid && in_tlast) begin
                        state <= LIM_PASS;
                    end
                end
                default: begin
                    state <= LIM_PASS;
                end
            endcase
        end
    end

endmodule

/* design/axis_stream_if.sv */
////////////////////////////////////////////////////////////////////////////
// Internal AXI-Stream link, no tid, tdest or tuser
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface axis_stream_if;

    import axis_fifo_pkg::*;

    // Handshake
    logic  tvalid;
    logic  tready;

    // Payload
    data_t tdata;
    keep_t tkeep;
    logic  tlast;

    // Set on the last word of a packet cut by the limiter
    logic  ttrunc;

    // Upstream side drives the word and valid
    modport source (
        output tvalid,
        input  tready,
        output tdata,
        output tkeep,
        output tlast,
        output ttrunc
    );

    // Downstream side only drives ready
    modport sink (
        input  tvalid,
        output tready,
        input  tdata,
        input  tkeep,
        input  tlast,
        input  ttrunc
    );

endinterface

/* include/axis_fifo_params.svh */
////////////////////////////////////////////////////////////////////////////
// Build-time sizes of the packet path. AXIS_FIFO_DEPTH must be a power of
// two, and AXIS_MAX_PKT_WORDS of at least 1
////////////////////////////////////////////////////////////////////////////

`ifndef AXIS_FIFO_PARAMS_SVH
`define AXIS_FIFO_PARAMS_SVH

// Stream width in bytes
// One word of tdata is 8 bits per byte
`define AXIS_DATA_BYTES 4

// Words held in the LUT RAM
// Output register adds one more word of storage
`define AXIS_FIFO_DEPTH 16

// Longest packet passed by the limiter, in words
// Longer packets are cut at this word and flagged
`define AXIS_MAX_PKT_WORDS 8

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the packet path testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=axis_fifo_tb
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module "$TOP" -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/V"$TOP" > "$SIM_LOG" 2>&1
SIM_STATUS=$?
cat "$SIM_LOG"
if [ $SIM_STATUS -ne 0 ]; then
    echo "Simulation exited with status $SIM_STATUS"
    exit 1
fi

if grep -q "Errors found" "$SIM_LOG"; then
    echo "Simulation reported failures, see $SIM_LOG"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

/* verif/axis_fifo_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for axis_fifo_top, assumes data, keep and last fit one word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "axis_fifo_params.svh"

module axis_fifo_tb;

    import axis_fifo_pkg::*;

    localparam int DB     = `AXIS_DATA_BYTES;
    localparam int WORD_W = DB * 8 + DB + 1;
    localparam int MAXW   = `AXIS_MAX_PKT_WORDS;
    // Words held with output stalled, RAM plus output register
    localparam int HOLD_W = `AXIS_FIFO_DEPTH + 1;
    localparam int SEED   = 32'h91a8_a455;

    logic       axis_out;
    logic       rst_n;
    logic       bp_en;
    logic       in_tvalid;
    logic       in_tready;
    data_t      in_tdata;
    keep_t      in_tkeep;
    logic       in_tlast;
    logic       out_tvalid;
    logic       out_tready;
    data_t      out_tdata;
    keep_t      out_tkeep;
    logic       out_tlast;
    logic       in_overflow;
    logic       pkt_done;
    pkt_bytes_t pkt_bytes;
    logic       pkt_truncated;

    // Model queues, output words as {data, keep, last}
    logic [WORD_W-1:0] exp_q [$];
    int                rep_bytes_q [$];
    bit                rep_trunc_q [$];

    string cur_test;
    int    err_cnt;
    int    err_base;
    int    test_cnt;
    int    fail_tests;
    int    ovf_cnt;
    int    ovf_base;
    int    exp_ovf;
    int    kept_words;
    int    in_hs_cnt;
    int    gen_words;
    int    cycles;
    bit    ready_random;

    axis_fifo_top dut_i (
        .axis_out      (axis_out),
        .rst_n         (rst_n),
        .bp_en         (bp_en),
        .in_tvalid     (in_tvalid),
        .in_tready     (in_tready),
        .in_tdata      (in_tdata),
        .in_tkeep      (in_tkeep),
        .in_tlast      (in_tlast),
        .out_tvalid    (out_tvalid),
        .out_tready    (out_tready),
        .out_tdata     (out_tdata),
        .out_tkeep     (out_tkeep),
        .out_tlast     (out_tlast),
        .in_overflow   (in_overflow),
        .pkt_done      (pkt_done),
        .pkt_bytes     (pkt_bytes),
        .pkt_truncated (pkt_truncated)
    );

    // 100 ns period
    always #50 axis_out = ~axis_out;

    task automatic check_value(input string what, input logic [WORD_W-1:0] exp,
                               input logic [WORD_W-1:0] act);
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Output side, sampled on the rising edge before any register update

    always @(posedge axis_out) begin
        if (rst_n) begin
            if (out_tvalid && out_tready) begin
                assert (exp_q.size() != 0) else begin
                    $display("Test %s: output word arrived with none expected", cur_test);
                    err_cnt++;
                end
                if (exp_q.size() != 0) begin
                    check_value("out word", exp_q.pop_front(),
                                {out_tdata, out_tkeep, out_tlast});
                end
            end
            if (pkt_done) begin
                assert (rep_bytes_q.size() != 0) else begin
                    $display("Test %s: pkt_done pulsed with no packet expected", cur_test);
                    err_cnt++;
                end
                if (rep_bytes_q.size() != 0) begin
                    check_value("pkt_bytes", WORD_W'(rep_bytes_q.pop_front()),
                                WORD_W'(pkt_bytes));
                    check_value("pkt_truncated", WORD_W'(rep_trunc_q.pop_front()),
                                WORD_W'(pkt_truncated));
                end
            end
            if (in_overflow) begin
                ovf_cnt++;
            end
        end
    end

    // Output ready, held low or random at 75 percent
    initial begin
        out_tready = 1'b0;
        forever begin
            @(negedge axis_out);
            out_tready = ready_random ? ($urandom_range(3, 0) != 0) : 1'b0;
        end
    end

    // Run limit grows with every generated word
    always @(posedge axis_out) begin
        cycles++;
        if (cycles > 8 * gen_words + 200) begin
            $display("Timeout after %0d cycles, the DUT stopped moving words", cycles);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus and model

    // Builds one packet, models it, then drives it word by word
    task automatic send_packet(input int len, input int max_gap, input bit lossy);
        data_t dq [$];
        keep_t kq [$];
        data_t data;
        keep_t keep;
        int    w;
        int    gap;
        int    nbytes;
        int    pkt_sum;
        bit    lost;
        logic  last_in;
        logic  last_out;
        pkt_sum = 0;
        lost    = 1'b0;
        gen_words += len;
        for (w = 0; w < len; w++) begin
            last_in = (w == len - 1);
            // Low-contiguous keep on the last word only
            nbytes = last_in ? $urandom_range(DB, 1) : DB;
            keep   = keep_t'((1 << nbytes) - 1);
            data   = data_t'($urandom);
            dq.push_back(data);
            kq.push_back(keep);
            // Tail past the limit never reaches the FIFO
            if (w < MAXW) begin
                last_out = last_in || (w == MAXW - 1);
                pkt_sum += nbytes;
                // Without back-pressure only the first DEPTH+1 words survive
                if (!lossy || kept_words < HOLD_W) begin
                    exp_q.push_back({data, keep, last_out});
                    kept_words++;
                end else begin
                    lost = 1'b1;
                end
            end
        end
        if (lost) begin
            exp_ovf++;
        end else begin
            rep_bytes_q.push_back(pkt_sum);
            rep_trunc_q.push_back(len > MAXW);
        end
        for (w = 0; w < len; w++) begin
            @(negedge axis_out);
            if (max_gap > 0) begin
                gap = $urandom_range(max_gap, 0);
                in_tvalid = 1'b0;
                repeat (gap) @(negedge axis_out);
            end
            in_tvalid = 1'b1;
            in_tdata  = dq[w];
            in_tkeep  = kq[w];
            in_tlast  = (w == len - 1);
            do begin
                @(posedge axis_out);
            end while (!in_tready);
            in_hs_cnt++;
        end
        @(negedge axis_out);
        in_tvalid = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test   = name;
        err_base   = err_cnt;
        ovf_base   = ovf_cnt;
        exp_ovf    = 0;
        kept_words = 0;
        in_hs_cnt  = 0;
    endtask

    // Drains the model, then checks overflow pulses and prints the result
    task automatic finish_test();
        int n;
        while (exp_q.size() != 0 || rep_bytes_q.size() != 0) begin
            @(negedge axis_out);
        end
        repeat (4) @(negedge axis_out);
        check_value("in_overflow pulses", WORD_W'(exp_ovf), WORD_W'(ovf_cnt - ovf_base));
        n = err_cnt - err_base;
        test_cnt++;
        if (n != 0) begin
            fail_tests++;
        end
        $display("Test %s %s, %0d failed checks", cur_test, (n == 0) ? "passed" : "failed", n);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        void'($urandom(SEED));
        axis_out     = 1'b0;
        rst_n        = 1'b0;
        bp_en        = 1'b1;
        in_tvalid    = 1'b0;
        in_tdata     = '0;
        in_tkeep     = '0;
        in_tlast     = 1'b0;
        ready_random = 1'b0;
        repeat (5) @(negedge axis_out);
        rst_n = 1'b1;

        // Quiet outputs before any input
        start_test("reset_idle");
        repeat (3) begin
            @(negedge axis_out);
            check_value("out_tvalid", '0, WORD_W'(out_tvalid));
            check_value("pkt_done", '0, WORD_W'(pkt_done));
            check_value("in_overflow", '0, WORD_W'(in_overflow));
        end
        finish_test();

        start_test("bp_random");
        ready_random = 1'b1;
        repeat (12) send_packet($urandom_range(MAXW, 1), 3, 1'b0);
        finish_test();

        start_test("bp_truncate");
        repeat (6) send_packet($urandom_range(MAXW + 4, MAXW + 1), 2, 1'b0);
        finish_test();

        // Stalled output, input must stop at DEPTH+1 words
        start_test("bp_hold");
        ready_random = 1'b0;
        fork
            repeat (HOLD_W / MAXW + 1) send_packet(MAXW, 0, 1'b0);
            begin
                while (in_hs_cnt < HOLD_W) @(negedge axis_out);
                repeat (4) @(negedge axis_out);
                check_value("in_tready when full", '0, WORD_W'(in_tready));
                check_value("words accepted", WORD_W'(HOLD_W), WORD_W'(in_hs_cnt));
                ready_random = 1'b1;
            end
        join
        finish_test();

        // No back-pressure, burst into a stalled empty FIFO
        start_test("drop_burst");
        bp_en        = 1'b0;
        ready_random = 1'b0;
        repeat (7) send_packet($urandom_range(MAXW, 3), 1, 1'b1);
        repeat (4) @(negedge axis_out);
        ready_random = 1'b1;
        finish_test();

        $display("Summary: %0d tests, %0d failed tests, %0d failed checks",
                 test_cnt, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
design/axis_fifo_pkg.sv
design/axis_stream_if.sv
design/axis_pkt_limiter.sv
design/axis_dist_ram_fifo.sv
design/axis_pkt_byte_counter.sv
design/axis_fifo_top.sv
verif/axis_fifo_tb.sv
